// File: src/snac_cfg_pkg.sv
/*
  Clock and polling-rate constants for the SNAC serial-latch adapter.
  Step sizes assume a 50 MHz core clock and a 32-bit phase accumulator.
  The strobe runs at twice the bit rate, so each step uses 2x the poll frequency.
*/
`default_nettype none

package snac_cfg_pkg;

    // core clock in Hz
    localparam int unsigned MASTER_CLK_FREQ = 50_000_000;

    // polling rates per controller family
    localparam int unsigned SNES_POLL_FREQ            = 50_000;
    localparam int unsigned SERLATCH_NORMAL_POLL_FREQ = 200_000;
    localparam int unsigned SERLATCH_FAST_POLL_FREQ   = 400_000;

    localparam int unsigned STEP_W = 32;

    // 2^32 * 2f / fclk, rounded down
    localparam logic [STEP_W-1:0] SNES_STEP = STEP_W'(
        ((64'd1 << STEP_W) * (2 * SNES_POLL_FREQ)) / MASTER_CLK_FREQ);
    localparam logic [STEP_W-1:0] SERLATCH_NORMAL_STEP = STEP_W'(
        ((64'd1 << STEP_W) * (2 * SERLATCH_NORMAL_POLL_FREQ)) / MASTER_CLK_FREQ);
    localparam logic [STEP_W-1:0] SERLATCH_FAST_STEP = STEP_W'(
        ((64'd1 << STEP_W) * (2 * SERLATCH_FAST_POLL_FREQ)) / MASTER_CLK_FREQ);

    // cartridge pin direction levels
    localparam logic CART_DIR_IN  = 1'b0;
    localparam logic CART_DIR_OUT = 1'b1;

endpackage

`default_nettype wire

// File: src/snac_ctrl_pkg.sv
/*
  Controller types, reader states and button word layout.
  Only configuration A serial-latch types exist; any other code is disabled.
  Button words are active high, bit i holds the i-th serial bit.
*/
`default_nettype none

package snac_ctrl_pkg;

    // type codes as set by the host menu
    typedef enum logic [4:0] {
        GC_DISABLED  = 5'd0,
        GC_DB15      = 5'd1,
        GC_NES       = 5'd2,
        GC_SNES      = 5'd3,
        GC_DB15_FAST = 5'd9,
        GC_SNES_SWAP = 5'd11
    } gc_type_e;

    typedef enum logic [1:0] {
        IDLE,
        LATCH,
        CLK_LOW,
        CLK_HIGH
    } reader_state_e;

    typedef logic [15:0] btn_word_t;

    // frame lengths in bits
    localparam int unsigned BITS_NES  = 8;
    localparam int unsigned BITS_SNES = 16;
    localparam int unsigned BITS_DB15 = 12;

    // latch width in strobe ticks
    localparam int unsigned LATCH_TICKS = 2;

    // SNES face buttons touched by the swap
    localparam int unsigned SNES_A_BIT = 8;
    localparam int unsigned SNES_B_BIT = 0;
    localparam int unsigned SNES_X_BIT = 9;
    localparam int unsigned SNES_Y_BIT = 1;

    // Zapper lines in the player 2 word
    localparam int unsigned ZAPPER_TRIG_BIT  = 7;
    localparam int unsigned ZAPPER_LIGHT_BIT = 6;

endpackage

`default_nettype wire

// File: src/serlatch_if.sv
/*
  Serial-latch pad link. Clock and latch are shared by both pads,
  each pad returns its own data line, low active.
*/
`timescale 1ns/100ps
`default_nettype none

interface serlatch_if;
    logic pad_clk;
    logic pad_lat;
    logic dat1;
    logic dat2;

    modport reader (output pad_clk, output pad_lat, input dat1, input dat2);
    modport port   (input pad_clk, input pad_lat, output dat1, output dat2);
endinterface

`default_nettype wire

// File: src/snac_mode_ctrl.sv
/*
  Registers the controller type and picks the polling step.
  Any change of the type, or i_reset, raises o_change_reset for one cycle.
  Unknown type codes are treated as disabled with a zero step.
*/
`timescale 1ns/100ps
`default_nettype none

module snac_mode_ctrl
    import snac_cfg_pkg::*;
    import snac_ctrl_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire  [4:0]       i_game_cont_type,
    output gc_type_e         o_gc_type,
    output logic             o_change_reset,
    output logic [STEP_W-1:0] o_step,
    output logic             o_enable
);

    logic [4:0] type_r;
    gc_type_e   type_dec;

    // map the raw code onto the supported set
    always_comb begin
        case (i_game_cont_type)
            5'd1:    type_dec = GC_DB15;
            5'd2:    type_dec = GC_NES;
            5'd3:    type_dec = GC_SNES;
            5'd9:    type_dec = GC_DB15_FAST;
            5'd11:   type_dec = GC_SNES_SWAP;
            default: type_dec = GC_DISABLED;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            type_r         <= 5'd0;
            o_gc_type      <= GC_DISABLED;
            o_change_reset <= 1'b1;
            o_step         <= '0;
            o_enable       <= 1'b0;
        end else begin
            type_r         <= i_game_cont_type;
            o_gc_type      <= type_dec;
            // one pulse per change of the raw setting
            o_change_reset <= (type_r != i_game_cont_type);
            o_enable       <= (type_dec != GC_DISABLED);
            case (type_dec)
                GC_NES, GC_SNES, GC_SNES_SWAP: o_step <= SNES_STEP;
                GC_DB15:                       o_step <= SERLATCH_NORMAL_STEP;
                GC_DB15_FAST:                  o_step <= SERLATCH_FAST_STEP;
                default:                       o_step <= '0;
            endcase
        end
    end

    // an enabled reader must get strobes
    a_enable_step : assert property (@(posedge i_clk) disable iff (i_reset)
        o_enable |-> (o_step != '0));

endmodule

`default_nettype wire

// File: src/snac_strobe_gen.sv
/*
  Fractional divider, strobe rate = fclk * step / 2^32.
  Pulse spacing jitters by one clock. A zero step never strobes.
*/
`timescale 1ns/100ps
`default_nettype none

module snac_strobe_gen
    import snac_cfg_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_reset,
    input  wire  [STEP_W-1:0] i_step,
    output logic              o_stb
);

    logic [STEP_W-1:0] acc;

    // carry out of the phase accumulator is the strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            acc   <= '0;
            o_stb <= 1'b0;
        end else begin
            {o_stb, acc} <= {1'b0, acc} + {1'b0, i_step};
        end
    end

    // below half scale a carry cannot repeat on the next add
    a_stb_gap : assert property (@(posedge i_clk) disable iff (i_reset)
        o_stb |=> (i_step[STEP_W-1] || !o_stb));

endmodule

`default_nettype wire

// File: src/serlatch_reader.sv
/*
  Latch/clock reader for two NES, SNES or DB15 pads sharing clock and latch.
  One frame per strobe run: latch for LATCH_TICKS strobes, then two strobes per bit.
  Data is sampled on the rising pad clock; pressed buttons read as 1.
  i_reset is expected to carry the type-change reset, which aborts a frame.
*/
`timescale 1ns/100ps
`default_nettype none

module serlatch_reader
    import snac_ctrl_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire         i_enable,
    input  wire gc_type_e i_gc_type,
    input  wire         i_stb,
    serlatch_if.reader  pad,
    output btn_word_t   o_p1_raw,
    output btn_word_t   o_p2_raw,
    output logic        o_frame_done,
    output logic        o_busy
);

    localparam int unsigned LAT_W = $clog2(LATCH_TICKS + 1);

    reader_state_e    state;
    logic [LAT_W-1:0] lat_cnt;
    logic [4:0]       bit_cnt;
    logic [4:0]       frame_len;
    logic             start;
    logic             sample;

    // bits per frame for the selected pad family
    always_comb begin
        case (i_gc_type)
            GC_DB15, GC_DB15_FAST:  frame_len = 5'(BITS_DB15);
            GC_SNES, GC_SNES_SWAP:  frame_len = 5'(BITS_SNES);
            default:                frame_len = 5'(BITS_NES);
        endcase
    end

    assign start  = (state == IDLE) && i_stb && i_enable;
    assign sample = (state == CLK_LOW) && i_stb;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= IDLE;
            pad.pad_lat  <= 1'b0;
            pad.pad_clk  <= 1'b1;
            lat_cnt      <= '0;
            bit_cnt      <= '0;
            o_frame_done <= 1'b0;
            o_busy       <= 1'b0;
        end else begin
            o_frame_done <= 1'b0;
            case (state)
                IDLE: if (start) begin
                    state       <= LATCH;
                    pad.pad_lat <= 1'b1;
                    lat_cnt     <= '0;
                    bit_cnt     <= '0;
                    o_busy      <= 1'b1;
                end
                LATCH: if (i_stb) begin
                    if (lat_cnt == LAT_W'(LATCH_TICKS - 1)) begin
                        pad.pad_lat <= 1'b0;
                        state       <= CLK_HIGH;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                // first strobe of a bit drops the clock
                CLK_HIGH: if (i_stb) begin
                    pad.pad_clk <= 1'b0;
                    state       <= CLK_LOW;
                end
                // second strobe raises it, data sampled below
                CLK_LOW: if (i_stb) begin
                    pad.pad_clk <= 1'b1;
                    if (bit_cnt == frame_len - 5'd1) begin
                        state        <= IDLE;
                        o_frame_done <= 1'b1;
                        o_busy       <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 5'd1;
                        state   <= CLK_HIGH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // shift registers, cleared at frame start so unused bits stay zero
    always_ff @(posedge i_clk) begin
        if (start) begin
            o_p1_raw <= '0;
            o_p2_raw <= '0;
        end else if (sample) begin
            o_p1_raw[bit_cnt[3:0]] <= ~pad.dat1;
            o_p2_raw[bit_cnt[3:0]] <= ~pad.dat2;
        end
    end

    // pads would shift on a clock edge during latch
    a_lat_clk : assert property (@(posedge i_clk) disable iff (i_reset)
        !(pad.pad_lat && !pad.pad_clk));

endmodule

`default_nettype wire

// File: src/snac_port_map.sv
/*
  Configuration A cartridge routing: bank 0 in, bank 1 bits 7:6 and pin 30 out, pin 31 in.
  IN4 = bank0[7], IN7 = bank0[5], IO3 = bank0[4], IO6 = pin 31; bank0[6] is unused here.
  o_zapper is {trigger, light}, raw levels after a 2-stage synchronizer.
*/
`timescale 1ns/100ps
`default_nettype none

module snac_port_map
    import snac_cfg_pkg::*;
    import snac_ctrl_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_reset,
    input  wire gc_type_e i_gc_type,
    serlatch_if.port      pad,
    input  wire  [7:4]    i_cart_bk0,
    input  wire           i_cart_pin31,
    output logic          o_cart_bk0_dir,
    output logic [1:0]    o_cart_bk1_p76,
    output logic          o_cart_pin30,
    output logic          o_cart_pin30_dir,
    output logic          o_cart_pin31_dir,
    output logic [1:0]    o_zapper
);

    logic io3_r;
    logic io6_r;
    logic in7_r;
    logic [1:0] trig_sync;
    logic [1:0] light_sync;

    // input pins, one register stage
    always_ff @(posedge i_clk) begin
        io3_r <= i_cart_bk0[4];
        in7_r <= i_cart_bk0[5];
        io6_r <= i_cart_pin31;
        trig_sync  <= {trig_sync[0], i_cart_bk0[7]};
        light_sync <= {light_sync[0], i_cart_pin31};
    end

    // DB15 data may arrive on either IO3 or IO6 for crossed cables
    assign pad.dat1 = (i_gc_type == GC_DB15 || i_gc_type == GC_DB15_FAST) ?
                      (io3_r & io6_r) : io3_r;
    assign pad.dat2 = in7_r;
    assign o_zapper = {trig_sync[1], light_sync[1]};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            // idle link: clock high, latch low
            o_cart_bk1_p76 <= 2'b01;
            o_cart_pin30   <= 1'b1;
        end else begin
            // OUT2 latch on bit 1, OUT1 clock on bit 0
            o_cart_bk1_p76 <= {pad.pad_lat, pad.pad_clk};
            // second pad clock mirrors OUT1
            o_cart_pin30   <= pad.pad_clk;
        end
        o_cart_bk0_dir   <= CART_DIR_IN;
        o_cart_pin30_dir <= CART_DIR_OUT;
        o_cart_pin31_dir <= CART_DIR_IN;
    end

endmodule

`default_nettype wire

// File: src/snac_player_out.sv
/*
  Player button words, loaded one cycle after frame-done and held between frames.
  SNES swap exchanges A/B and X/Y on both players.
  NES puts the inverted Zapper trigger/light on player 2 bits 7:6.
*/
`timescale 1ns/100ps
`default_nettype none

module snac_player_out
    import snac_ctrl_pkg::*;
(
    input  wire            i_clk,
    input  wire            i_reset,
    input  wire gc_type_e  i_gc_type,
    input  wire            i_frame_done,
    input  wire btn_word_t i_p1_raw,
    input  wire btn_word_t i_p2_raw,
    input  wire [1:0]      i_zapper,
    output btn_word_t      o_p1_btn_state,
    output btn_word_t      o_p2_btn_state
);

    btn_word_t p1_next;
    btn_word_t p2_next;

    function automatic btn_word_t swap_ab_xy(input btn_word_t w);
        btn_word_t r;
        r = w;
        r[SNES_A_BIT] = w[SNES_B_BIT];
        r[SNES_B_BIT] = w[SNES_A_BIT];
        r[SNES_X_BIT] = w[SNES_Y_BIT];
        r[SNES_Y_BIT] = w[SNES_X_BIT];
        return r;
    endfunction

    always_comb begin
        p1_next = i_p1_raw;
        p2_next = i_p2_raw;
        case (i_gc_type)
            GC_SNES_SWAP: begin
                p1_next = swap_ab_xy(i_p1_raw);
                p2_next = swap_ab_xy(i_p2_raw);
            end
            // Zapper lines are low active
            GC_NES: begin
                p2_next[ZAPPER_TRIG_BIT]  = ~i_zapper[1];
                p2_next[ZAPPER_LIGHT_BIT] = ~i_zapper[0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_gc_type == GC_DISABLED) begin
            o_p1_btn_state <= '0;
            o_p2_btn_state <= '0;
        end else if (i_frame_done) begin
            o_p1_btn_state <= p1_next;
            o_p2_btn_state <= p2_next;
        end
    end

endmodule

`default_nettype wire

// File: src/snac_adapter.sv
/*
  SNAC adapter top, configuration A serial-latch pads only (DB15, NES, SNES).
  i_game_cont_type codes outside 1, 2, 3, 9 and 11 disable the adapter.
  o_busy is high while a frame is being read; o_stb is the raw polling strobe.
*/
`timescale 1ns/100ps
`default_nettype none

module snac_adapter
    import snac_cfg_pkg::*;
    import snac_ctrl_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_reset,
    input  wire  [4:0] i_game_cont_type,
    input  wire  [7:4] i_cart_bk0,
    input  wire        i_cart_pin31,
    output logic       o_cart_bk0_dir,
    output logic [1:0] o_cart_bk1_p76,
    output logic       o_cart_pin30,
    output logic       o_cart_pin30_dir,
    output logic       o_cart_pin31_dir,
    output btn_word_t  o_p1_btn_state,
    output btn_word_t  o_p2_btn_state,
    output logic       o_busy,
    output logic       o_stb
);

    gc_type_e          gc_type;
    logic              change_reset;
    logic [STEP_W-1:0] step;
    logic              enable;
    btn_word_t         p1_raw;
    btn_word_t         p2_raw;
    logic              frame_done;
    logic [1:0]        zapper;

    serlatch_if pad_bus ();

    snac_mode_ctrl u_mode_ctrl (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_game_cont_type (i_game_cont_type),
        .o_gc_type        (gc_type),
        .o_change_reset   (change_reset),
        .o_step           (step),
        .o_enable         (enable)
    );

    // divider and reader restart on every type change
    snac_strobe_gen u_strobe_gen (
        .i_clk   (i_clk),
        .i_reset (change_reset),
        .i_step  (step),
        .o_stb   (o_stb)
    );

    serlatch_reader u_reader (
        .i_clk        (i_clk),
        .i_reset      (change_reset),
        .i_enable     (enable),
        .i_gc_type    (gc_type),
        .i_stb        (o_stb),
        .pad          (pad_bus.reader),
        .o_p1_raw     (p1_raw),
        .o_p2_raw     (p2_raw),
        .o_frame_done (frame_done),
        .o_busy       (o_busy)
    );

    snac_port_map u_port_map (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_gc_type        (gc_type),
        .pad              (pad_bus.port),
        .i_cart_bk0       (i_cart_bk0),
        .i_cart_pin31     (i_cart_pin31),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_bk1_p76   (o_cart_bk1_p76),
        .o_cart_pin30     (o_cart_pin30),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir),
        .o_zapper         (zapper)
    );

    snac_player_out u_player_out (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_gc_type      (gc_type),
        .i_frame_done   (frame_done),
        .i_p1_raw       (p1_raw),
        .i_p2_raw       (p2_raw),
        .i_zapper       (zapper),
        .o_p1_btn_state (o_p1_btn_state),
        .o_p2_btn_state (o_p2_btn_state)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
  Testbench clock and reset source.
  Reset is high from time zero and released on a rising edge.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD_NS = 50,
    parameter int unsigned RESET_CYCLES   = 2
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // synchronous release after the reset cycles
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/snac_adapter_tb.sv
/*
  Testbench for the configuration A SNAC adapter with two serial-latch pad models.
  Pads load their pattern while the latch is high and shift on each rising pad clock.
  For DB15 a third line on pin 31 is ANDed with IO3 inside the DUT.
  Expected words are rebuilt from the patterns that the pads actually latched.
*/
`timescale 1ns/100ps
`default_nettype none

module snac_adapter_tb
    import snac_cfg_pkg::*;
    import snac_ctrl_pkg::*;
();

    localparam int unsigned NUM_TESTS         = 5;
    localparam int unsigned FRAMES_PER_TEST   = 4;
    // SNES strobe period in cycles, rounded up
    localparam int unsigned SNES_STB_GAP      = int'((64'd1 << STEP_W) / SNES_STEP) + 1;
    // start strobe, latch, then two strobes per bit
    localparam int unsigned SNES_FRAME_CYCLES = (1 + LATCH_TICKS + 2 * BITS_SNES) * SNES_STB_GAP;
    localparam int unsigned TIMEOUT_CYCLES    = NUM_TESTS * FRAMES_PER_TEST * SNES_FRAME_CYCLES;
    localparam int unsigned RATE_WINDOW       = 10_000;

    logic       clk;
    logic       rst;
    logic [4:0] cont_type;
    logic [7:4] cart_bk0;
    logic       cart_pin31;
    logic       cart_bk0_dir;
    logic [1:0] cart_bk1_p76;
    logic       cart_pin30;
    logic       cart_pin30_dir;
    logic       cart_pin31_dir;
    btn_word_t  p1_btn;
    btn_word_t  p2_btn;
    logic       busy;
    logic       stb;

    // pad state and scoreboard
    gc_type_e    cur_type = GC_DISABLED;
    btn_word_t   pat1;
    btn_word_t   pat2;
    btn_word_t   pat3;
    btn_word_t   lat_pat1 = '0;
    btn_word_t   lat_pat2 = '0;
    btn_word_t   lat_pat3 = '0;
    btn_word_t   sr1 = '0;
    btn_word_t   sr2 = '0;
    btn_word_t   sr3 = '0;
    btn_word_t   last_p1 = '0;
    btn_word_t   last_p2 = '0;
    logic        pclk_prev = 1'b1;
    logic        zap_trig = 1'b1;
    logic        zap_light = 1'b1;
    logic        check_en = 1'b0;
    logic        pending = 1'b0;
    logic        busy_prev = 1'b0;
    logic [31:0] exp_words;
    int          frames_done = 0;
    int          checks = 0;
    int          errors = 0;
    int unsigned cycles = 0;
    string       test_name = "init";

    tb_clock_gen #(.HALF_PERIOD_NS(50), .RESET_CYCLES(2)) u_clock_gen (
        .o_clk   (clk),
        .o_reset (rst)
    );

    snac_adapter UUT (
        .i_clk            (clk),
        .i_reset          (rst),
        .i_game_cont_type (cont_type),
        .i_cart_bk0       (cart_bk0),
        .i_cart_pin31     (cart_pin31),
        .o_cart_bk0_dir   (cart_bk0_dir),
        .o_cart_bk1_p76   (cart_bk1_p76),
        .o_cart_pin30     (cart_pin30),
        .o_cart_pin30_dir (cart_pin30_dir),
        .o_cart_pin31_dir (cart_pin31_dir),
        .o_p1_btn_state   (p1_btn),
        .o_p2_btn_state   (p2_btn),
        .o_busy           (busy),
        .o_stb            (stb)
    );

    // expected {p2, p1} from the latched patterns, pressed = 1
    function automatic logic [31:0] expected_words(input gc_type_e t, input btn_word_t a,
                                                   input btn_word_t b, input btn_word_t c,
                                                   input logic trig, input logic light);
        btn_word_t   e1;
        btn_word_t   e2;
        logic [31:0] mask;
        int unsigned len;
        case (t)
            GC_NES:                len = BITS_NES;
            GC_SNES, GC_SNES_SWAP: len = BITS_SNES;
            GC_DB15, GC_DB15_FAST: len = BITS_DB15;
            default:               len = 0;
        endcase
        mask = (32'd1 << len) - 32'd1;
        // low-active lines ANDed means either contact pressed
        e1 = (t == GC_DB15 || t == GC_DB15_FAST) ? (a | c) : a;
        e1 = e1 & mask[15:0];
        e2 = b & mask[15:0];
        if (t == GC_SNES_SWAP) begin
            // A(8) <-> B(0), X(9) <-> Y(1)
            e1 = {e1[15:10], e1[1], e1[0], e1[7:2], e1[9], e1[8]};
            e2 = {e2[15:10], e2[1], e2[0], e2[7:2], e2[9], e2[8]};
        end
        if (t == GC_NES) begin
            e2[ZAPPER_TRIG_BIT]  = ~trig;
            e2[ZAPPER_LIGHT_BIT] = ~light;
        end
        return {e2, e1};
    endfunction

    task automatic check_word(input string label, input btn_word_t exp, input btn_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s / %s: expected %h, actual %h", test_name, label, exp, act);
        end
    endtask

    task automatic check_bit(input string label, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s / %s: expected %b, actual %b", test_name, label, exp, act);
        end
    endtask

    // fresh button patterns, SNES pads report bits 15:12 released
    task automatic new_patterns();
        logic [31:0] rnd;
        rnd  = $urandom;
        pat1 = rnd[15:0];
        pat3 = rnd[31:16];
        rnd  = $urandom;
        pat2 = rnd[15:0];
        if (cur_type == GC_SNES || cur_type == GC_SNES_SWAP) begin
            pat1 = pat1 & 16'h0FFF;
            pat2 = pat2 & 16'h0FFF;
        end
    endtask

    // checks are off while the type changes, any frame in flight is aborted
    task automatic set_type(input gc_type_e t);
        check_en = 1'b0;
        cur_type = t;
        new_patterns();
        @(posedge clk);
        cont_type <= t;
        repeat (4) @(posedge clk);
        check_en = 1'b1;
    endtask

    task automatic run_frames(input int n);
        int target;
        repeat (n) begin
            target = frames_done + 1;
            wait (frames_done >= target);
            new_patterns();
        end
    endtask

    task automatic count_strobes(input int unsigned window, output int n);
        n = 0;
        repeat (window) begin
            @(negedge clk);
            if (stb) n++;
        end
    endtask

    // pad 1 on IO3, pad 2 on IN7, second DB15 contact on IO6
    always @(posedge clk) begin
        if (cart_bk1_p76[1]) begin
            sr1      = pat1;
            sr2      = pat2;
            sr3      = pat3;
            lat_pat1 = pat1;
            lat_pat2 = pat2;
            lat_pat3 = pat3;
        end else if (cart_bk1_p76[0] && !pclk_prev) begin
            // released buttons shift in behind the frame
            sr1 = sr1 >> 1;
            sr2 = sr2 >> 1;
            sr3 = sr3 >> 1;
        end
        pclk_prev = cart_bk1_p76[0];
        cart_bk0  <= {zap_trig, 1'b1, ~sr2[0], ~sr1[0]};
        if (cur_type == GC_DB15 || cur_type == GC_DB15_FAST) begin
            cart_pin31 <= ~sr3[0];
        end else begin
            cart_pin31 <= zap_light;
        end
    end

    // words are compared one cycle after busy falls
    always @(negedge clk) begin
        if (pending) begin
            pending   = 1'b0;
            exp_words = expected_words(cur_type, lat_pat1, lat_pat2, lat_pat3,
                                       zap_trig, zap_light);
            check_word("p1 word", exp_words[15:0], p1_btn);
            check_word("p2 word", exp_words[31:16], p2_btn);
            // the second pad clock is back at its idle high level after the last bit
            check_bit("pin 30 clock", 1'b1, cart_pin30);
            last_p1 = exp_words[15:0];
            last_p2 = exp_words[31:16];
            frames_done++;
        end
        if (busy_prev && !busy) begin
            pending = check_en;
        end
        busy_prev = busy;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin : stimulus
        int          n_norm;
        int          n_fast;
        cont_type  = 5'd0;
        cart_bk0   = 4'hF;
        cart_pin31 = 1'b1;
        // one seed for the whole run
        void'($urandom(63));
        new_patterns();
        wait (rst == 1'b0);
        repeat (2) @(posedge clk);

        test_name = "reset";
        count_strobes(2000, n_norm);
        check_bit("no strobe", 1'b0, n_norm != 0);
        check_word("p1 cleared", '0, p1_btn);
        check_word("p2 cleared", '0, p2_btn);
        check_bit("busy", 1'b0, busy);
        check_bit("bank 0 dir", CART_DIR_IN, cart_bk0_dir);
        check_bit("pin 30 dir", CART_DIR_OUT, cart_pin30_dir);
        check_bit("pin 31 dir", CART_DIR_IN, cart_pin31_dir);
        check_bit("latch idle", 1'b0, cart_bk1_p76[1]);
        check_bit("pad clock idle", 1'b1, cart_bk1_p76[0]);

        test_name = "snes";
        set_type(GC_SNES);
        run_frames(4);
        check_word("p1 bits 15:12", '0, p1_btn & 16'hF000);
        check_word("p2 bits 15:12", '0, p2_btn & 16'hF000);

        test_name = "snes swap";
        set_type(GC_SNES_SWAP);
        run_frames(2);

        // trigger pulled, no light, then the opposite
        test_name = "nes zapper";
        zap_trig  = 1'b0;
        zap_light = 1'b1;
        set_type(GC_NES);
        run_frames(2);
        zap_trig  = 1'b1;
        zap_light = 1'b0;
        run_frames(1);
        check_word("p2 bits 15:8", '0, p2_btn & 16'hFF00);

        // both windows start right after the accumulator clears
        test_name = "db15";
        set_type(GC_DB15);
        count_strobes(RATE_WINDOW, n_norm);
        run_frames(3);
        test_name = "db15 fast";
        set_type(GC_DB15_FAST);
        count_strobes(RATE_WINDOW, n_fast);
        run_frames(3);
        check_bit("strobe rate x2", 1'b1,
                  (n_fast <= 2 * n_norm + 1) && (n_fast + 1 >= 2 * n_norm));

        test_name = "type change";
        set_type(GC_SNES);
        run_frames(1);
        while (!busy) @(negedge clk);
        // well inside the SNES frame
        repeat (3000) @(negedge clk);
        set_type(GC_NES);
        @(negedge clk);
        check_bit("frame aborted", 1'b0, busy);
        check_word("p1 held", last_p1, p1_btn);
        check_word("p2 held", last_p2, p2_btn);
        run_frames(2);
        set_type(GC_DISABLED);
        @(negedge clk);
        check_word("p1 disabled", '0, p1_btn);
        check_word("p2 disabled", '0, p2_btn);
        check_bit("busy disabled", 1'b0, busy);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: snac_adapter.f
src/snac_cfg_pkg.sv
src/snac_ctrl_pkg.sv
src/serlatch_if.sv
src/snac_mode_ctrl.sv
src/snac_strobe_gen.sv
src/serlatch_reader.sv
src/snac_port_map.sv
src/snac_player_out.sv
src/snac_adapter.sv
tests/tb_clock_gen.sv
tests/snac_adapter_tb.sv

// File: Bender.yml
package:
  name: snac_adapter

sources:
  - src/snac_cfg_pkg.sv
  - src/snac_ctrl_pkg.sv
  - src/serlatch_if.sv
  - src/snac_mode_ctrl.sv
  - src/snac_strobe_gen.sv
  - src/serlatch_reader.sv
  - src/snac_port_map.sv
  - src/snac_player_out.sv
  - src/snac_adapter.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/snac_adapter_tb.sv
